/* dv/testdata_program.txt */
# Tag B: one host data byte in hex, in send order
# Tag P: busy status answers in hex before the word whose bytes follow
P 2
B a5
B 3c
B 0f
B e1
P 0
B 5a
B c3
B 81
B 7e
P 3
B 12
B 34
B 56
B 78

/* files.f */
source/spi_prog_pkg.sv
source/host_byte_buffer.sv
source/spi_clock_timebase.sv
source/spi_shift_engine.sv
source/flash_program_sequencer.sv
source/spi_flash_programmer.sv
dv/spi_flash_responder.sv
dv/tb_spi_flash_programmer.sv

/* dv/tb_spi_flash_programmer.sv */
// SPI flash programmer testbench
module tb_spi_flash_programmer;

   localparam int                        SPI_CLK_RATIO = 4;
   localparam int                        PROG_TIME     = 16;
   localparam int                        WORD_COUNT    = 3;
   localparam spi_prog_pkg::flash_addr_t START_ADDR    = 24'h000100;
   localparam int                        FIFO_DEPTH    = 4;

   localparam int CLK_PERIOD   = 20;
   localparam int DRIVE_DELAY  = 2;
   localparam int WAIT_LIMIT   = 4000;  // Cycles allowed for any single wait.
   localparam int STALL_BYTE   = 2 * spi_prog_pkg::BYTES_PER_WORD - 1;  // Last byte of word 1.
   localparam int STALL_DELAY  = 80 * SPI_CLK_RATIO;  // Past opcode, address and three bytes.
   localparam int STALL_WINDOW = 10 * SPI_CLK_RATIO;

   logic                     HCLK;
   logic                     HRESETN;
   logic                     start_program;
   spi_prog_pkg::host_byte_t host_in;
   logic                     credit_return;
   logic                     done;
   logic                     sdi;
   spi_prog_pkg::spi_pins_t  pins;

   int          busy_polls;
   int          frame_count;
   logic [63:0] frame_bits;    // Frame bytes, first byte in the top bits.
   int          frame_nbytes;
   time         frame_start;
   time         frame_end;

   spi_prog_pkg::byte_t host_bytes[$];
   int                  busy_counts[$];
   int                  frames_taken   = 0;
   int                  wren_seen      = 0;
   int                  sent_count     = 0;
   int                  returned_count = 0;
   int                  error_count    = 0;
   int                  abort_count    = 0;

   spi_flash_programmer #(
      .SPI_CLK_RATIO (SPI_CLK_RATIO),
      .PROG_TIME     (PROG_TIME),
      .WORD_COUNT    (WORD_COUNT),
      .START_ADDR    (START_ADDR),
      .FIFO_DEPTH    (FIFO_DEPTH)
   ) i_spi_flash_programmer (
      .HCLK          (HCLK),
      .HRESETN       (HRESETN),
      .start_program (start_program),
      .host_in       (host_in),
      .credit_return (credit_return),
      .done          (done),
      .sdi           (sdi),
      .pins          (pins)
   );

   spi_flash_responder i_spi_flash_responder (
      .pins         (pins),
      .busy_polls   (busy_polls),
      .sdi          (sdi),
      .frame_count  (frame_count),
      .frame_bits   (frame_bits),
      .frame_nbytes (frame_nbytes),
      .frame_start  (frame_start),
      .frame_end    (frame_end)
   );

   initial
   begin
      HCLK = 1'b0;
      forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
   end

   // Host credits are FIFO_DEPTH - sent + returned and must stay in range.
   always @(negedge HCLK)
   begin
      if (credit_return === 1'b1)
         returned_count = returned_count + 1;
      if (sent_count - returned_count > FIFO_DEPTH || returned_count > sent_count)
      begin
         error_count++;
         $display("** Error at %0t: host credits out of range, sent %0d returned %0d",
                  $time, sent_count, returned_count);
      end
   end

   task automatic finish_run();
      $display("Summary: %0d value errors, %0d aborted waits", error_count, abort_count);
      if (error_count == 0 && abort_count == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   endtask

   task automatic abort_run(input string what);
      $display("Run stopped at %0t: %s", $time, what);
      abort_count++;
      finish_run();
   endtask

   task automatic check_byte(input spi_prog_pkg::byte_t got, input spi_prog_pkg::byte_t exp,
                             input string what);
      if (got !== exp)
      begin
         error_count++;
         $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_addr(input spi_prog_pkg::flash_addr_t got,
                             input spi_prog_pkg::flash_addr_t exp, input string what);
      if (got !== exp)
      begin
         error_count++;
         $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp)
      begin
         error_count++;
         $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         error_count++;
         $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_pins(input spi_prog_pkg::spi_pins_t got,
                             input spi_prog_pkg::spi_pins_t exp, input string what);
      if (got !== exp)
      begin
         error_count++;
         $display("** Error at %0t: %s (sck sdo ss_n) are %b, expected %b",
                  $time, what, got, exp);
      end
   endtask

   // Tag B lines hold host bytes, tag P lines hold busy answers per word.
   task automatic load_test_data();
      int         fd;
      int         code;
      int         ch;
      logic [7:0] tag;
      logic [7:0] value;
      fd = $fopen("dv/testdata_program.txt", "r");
      if (fd == 0)
         abort_run("cannot open dv/testdata_program.txt");
      else
      begin
         while ($fscanf(fd, " %c", tag) == 1)
         begin
            if (tag == "#")
            begin
               ch = 0;
               while (ch != 10 && ch != -1)
                  ch = $fgetc(fd);
            end
            else
            begin
               code = $fscanf(fd, " %h", value);
               if (code == 1 && tag == "B")
                  host_bytes.push_back(value);
               else if (code == 1 && tag == "P")
                  busy_counts.push_back(int'(value));
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic wait_for_frame();
      int cycles;
      cycles = 0;
      while (frame_count == frames_taken && cycles < WAIT_LIMIT)
      begin
         @(negedge HCLK);
         cycles++;
      end
      if (frame_count == frames_taken)
         abort_run("no SPI frame came from the programmer");
      else
         frames_taken++;
   endtask

   task automatic wait_for_done(input logic level);
      int cycles;
      cycles = 0;
      while (done !== level && cycles < WAIT_LIMIT)
      begin
         @(negedge HCLK);
         cycles++;
      end
      if (done !== level)
         abort_run(level ? "done never rose" : "done never fell");
   endtask

   // Status polls, write enable, then the program frame of one word.
   task automatic check_word(input int w);
      time wren_end;
      int  gap;
      spi_prog_pkg::flash_addr_t exp_addr;
      exp_addr = START_ADDR + spi_prog_pkg::flash_addr_t'(spi_prog_pkg::BYTES_PER_WORD * w);
      for (int s = 0; s <= busy_counts[w]; s++)
      begin
         wait_for_frame();
         check_byte(frame_bits[63:56], spi_prog_pkg::OP_READ_STATUS, "status poll opcode");
         check_count(frame_nbytes, 2, "status frame length");
      end
      wait_for_frame();
      check_byte(frame_bits[63:56], spi_prog_pkg::OP_WRITE_ENABLE, "write enable opcode");
      check_count(frame_nbytes, 1, "write enable frame length");
      wren_end = frame_end;
      wren_seen++;
      wait_for_frame();
      if (w + 1 < busy_counts.size())
         busy_polls = busy_counts[w + 1];  // Busy answers for the next word.
      check_byte(frame_bits[63:56], spi_prog_pkg::OP_PAGE_PROGRAM, "program opcode");
      check_count(frame_nbytes, 4 + spi_prog_pkg::BYTES_PER_WORD, "program frame length");
      check_addr(frame_bits[55:32], exp_addr, "program address");
      for (int b = 0; b < spi_prog_pkg::BYTES_PER_WORD; b++)
         check_byte(frame_bits[31 - 8 * b -: 8], host_bytes[4 * w + b], "program data byte");
      gap = int'((frame_start - wren_end) / CLK_PERIOD);
      if (gap < PROG_TIME)
      begin
         error_count++;
         $display("** Error at %0t: program frame began %0d cycles after write enable, min %0d",
                  $time, gap, PROG_TIME);
      end
   endtask

   task automatic send_host_byte(input spi_prog_pkg::byte_t data);
      int cycles;
      cycles = 0;
      @(posedge HCLK);
      #DRIVE_DELAY;
      while (sent_count - returned_count >= FIFO_DEPTH && cycles < WAIT_LIMIT)
      begin
         @(posedge HCLK);
         #DRIVE_DELAY;
         cycles++;
      end
      if (sent_count - returned_count >= FIFO_DEPTH)
         abort_run("the host never got a credit back");
      else
      begin
         host_in.valid = 1'b1;
         host_in.data  = data;
         sent_count++;
         @(posedge HCLK);
         #DRIVE_DELAY;
         host_in = '0;
      end
   endtask

   // Holds back the last byte of word 1 and watches the frame stand still.
   task automatic check_stalled_frame();
      int   cycles;
      int   rises;
      int   released;
      logic sck_q;
      cycles = 0;
      while (wren_seen < 2 && cycles < WAIT_LIMIT)
      begin
         @(negedge HCLK);
         cycles++;
      end
      cycles = 0;
      while (pins.ss_n !== 1'b0 && cycles < WAIT_LIMIT)
      begin
         @(negedge HCLK);
         cycles++;
      end
      if (wren_seen < 2 || pins.ss_n !== 1'b0)
         abort_run("the program frame of word 1 never started");
      else
      begin
         repeat (STALL_DELAY) @(negedge HCLK);
         rises    = 0;
         released = 0;
         sck_q    = pins.sck;
         repeat (STALL_WINDOW)
         begin
            @(negedge HCLK);
            if (pins.sck && !sck_q)
               rises++;
            if (pins.ss_n)
               released++;
            sck_q = pins.sck;
         end
         check_count(rises, 0, "sck edges while a host byte is missing");
         check_count(released, 0, "select high cycles while a host byte is missing");
      end
   endtask

   initial
   begin : host_driver
      int cycles;
      int gap;
      void'($urandom(10));
      cycles = 0;
      while (HRESETN !== 1'b1 && cycles < WAIT_LIMIT)
      begin
         @(posedge HCLK);
         cycles++;
      end
      for (int idx = 0; idx < host_bytes.size(); idx++)
      begin
         if (idx == STALL_BYTE)
            check_stalled_frame();
         gap = $urandom % 4;  // Idle cycles before this byte.
         repeat (gap) @(posedge HCLK);
         send_host_byte(host_bytes[idx]);
      end
   end

   initial
   begin : main_sequence
      spi_prog_pkg::spi_pins_t pins_idle;
      int                      frames_before;
      int                      low_cycles;
      HRESETN       = 1'b0;
      start_program = 1'b0;
      host_in       = '0;
      busy_polls    = 0;
      load_test_data();
      check_count(host_bytes.size(), spi_prog_pkg::BYTES_PER_WORD * WORD_COUNT, "host bytes");
      check_count(busy_counts.size(), WORD_COUNT, "busy poll counts");
      busy_polls = busy_counts[0];
      repeat (8) @(posedge HCLK);
      #DRIVE_DELAY;
      HRESETN = 1'b1;
      repeat (2) @(negedge HCLK);
      pins_idle.sck  = 1'b0;
      pins_idle.sdo  = 1'b0;
      pins_idle.ss_n = 1'b1;
      check_pins(pins, pins_idle, "pins after reset");
      check_bit(done, 1'b0, "done after reset");
      check_bit(credit_return, 1'b0, "credit_return after reset");
      @(posedge HCLK);
      #DRIVE_DELAY;
      start_program = 1'b1;
      for (int w = 0; w < WORD_COUNT; w++)
         check_word(w);
      wait_for_done(1'b1);
      frames_before = frame_count;
      low_cycles    = 0;
      repeat (50 * SPI_CLK_RATIO)
      begin
         @(negedge HCLK);
         if (done !== 1'b1)
            low_cycles++;
      end
      check_count(frame_count - frames_before, 0, "frames after done");
      check_count(low_cycles, 0, "cycles with done low while start_program is high");
      @(posedge HCLK);
      #DRIVE_DELAY;
      start_program = 1'b0;
      wait_for_done(1'b0);
      check_count(sent_count, host_bytes.size(), "host bytes sent");
      check_count(returned_count, sent_count, "credit returns");
      finish_run();
   end

endmodule

/* dv/spi_flash_responder.sv */
// Behavioral SPI flash
module spi_flash_responder (
   input  spi_prog_pkg::spi_pins_t pins,
   input  int                      busy_polls,
   output logic                    sdi,
   output int                      frame_count,
   output logic [63:0]             frame_bits,
   output int                      frame_nbytes,
   output time                     frame_start,
   output time                     frame_end
);

   logic [63:0]         shift;
   int                  nbits;
   int                  status_seen;  // Status frames since the last program frame.
   logic                in_frame;
   time                 start_t;
   spi_prog_pkg::byte_t opcode;
   spi_prog_pkg::byte_t status;

   initial
   begin
      sdi          = 1'b0;
      frame_count  = 0;
      frame_bits   = '0;
      frame_nbytes = 0;
      frame_start  = 0;
      frame_end    = 0;
      shift        = '0;
      nbits        = 0;
      status_seen  = 0;
      in_frame     = 1'b0;
      start_t      = 0;
      opcode       = '0;
      status       = '0;
   end

   always @(negedge pins.ss_n)
   begin
      in_frame = 1'b1;
      nbits    = 0;
      shift    = '0;
      opcode   = '0;
      start_t  = $time;
   end

   // Flash samples sdo on the rising clock.
   always @(posedge pins.sck)
   begin
      if (in_frame && nbits < 64)
      begin
         shift = {shift[62:0], pins.sdo};
         nbits = nbits + 1;
         if (nbits == 8)
         begin
            opcode = shift[7:0];
            status = (status_seen < busy_polls) ? 8'h01 : 8'h00;  // Busy in bit 0.
         end
      end
   end

   // Status byte goes out on the falling clock, MSB first.
   always @(negedge pins.sck)
   begin
      if (in_frame && opcode == spi_prog_pkg::OP_READ_STATUS && nbits >= 8 && nbits < 16)
         sdi = status[15 - nbits];
   end

   always @(posedge pins.ss_n)
   begin
      if (in_frame)
      begin
         in_frame     = 1'b0;
         frame_bits   = shift << (64 - nbits);
         frame_nbytes = nbits / 8;
         frame_start  = start_t;
         frame_end    = $time;
         if (opcode == spi_prog_pkg::OP_READ_STATUS)
            status_seen = status_seen + 1;
         else if (opcode == spi_prog_pkg::OP_PAGE_PROGRAM)
            status_seen = 0;  // Next word starts a new poll count.
         sdi         = 1'b0;
         frame_count = frame_count + 1;
      end
   end

endmodule

/* source/spi_flash_programmer.sv */
// SPI flash programmer top level
module spi_flash_programmer #(
   parameter int                        SPI_CLK_RATIO = 4,
   parameter int                        PROG_TIME     = 16,
   parameter int                        WORD_COUNT    = 3,
   parameter spi_prog_pkg::flash_addr_t START_ADDR    = 24'h000100,
   parameter int                        FIFO_DEPTH    = 4
) (
   input  logic                     HCLK,
   input  logic                     HRESETN,
   input  logic                     start_program,
   input  spi_prog_pkg::host_byte_t host_in,
   output logic                     credit_return,
   output logic                     done,
   input  logic                     sdi,
   output spi_prog_pkg::spi_pins_t  pins
);

   spi_prog_pkg::host_byte_t head;
   spi_prog_pkg::spi_cmd_t   cmd;
   spi_prog_pkg::spi_rsp_t   rsp;
   logic                     pop;
   logic                     edge_lo;
   logic                     edge_hi;
   logic                     clock_en;

   host_byte_buffer #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) i_host_byte_buffer (
      .HCLK          (HCLK),
      .HRESETN       (HRESETN),
      .host_in       (host_in),
      .pop           (pop),
      .head          (head),
      .credit_return (credit_return)
   );

   flash_program_sequencer #(
      .PROG_TIME  (PROG_TIME),
      .WORD_COUNT (WORD_COUNT),
      .START_ADDR (START_ADDR)
   ) i_flash_program_sequencer (
      .HCLK          (HCLK),
      .HRESETN       (HRESETN),
      .start_program (start_program),
      .head          (head),
      .pop           (pop),
      .rsp           (rsp),
      .cmd           (cmd),
      .done          (done)
   );

   spi_shift_engine i_spi_shift_engine (
      .HCLK     (HCLK),
      .HRESETN  (HRESETN),
      .cmd      (cmd),
      .edge_lo  (edge_lo),
      .edge_hi  (edge_hi),
      .sdi      (sdi),
      .clock_en (clock_en),
      .sdo      (pins.sdo),
      .ss_n     (pins.ss_n),
      .rsp      (rsp)
   );

   spi_clock_timebase #(
      .SPI_CLK_RATIO (SPI_CLK_RATIO)
   ) i_spi_clock_timebase (
      .HCLK     (HCLK),
      .HRESETN  (HRESETN),
      .clock_en (clock_en),
      .edge_lo  (edge_lo),
      .edge_hi  (edge_hi),
      .sck      (pins.sck)
   );

endmodule

/* source/flash_program_sequencer.sv */
// Flash page program sequencer
module flash_program_sequencer #(
   parameter int                        PROG_TIME  = 16,
   parameter int                        WORD_COUNT = 4,
   parameter spi_prog_pkg::flash_addr_t START_ADDR = '0
) (
   input  logic                     HCLK,
   input  logic                     HRESETN,
   input  logic                     start_program,
   input  spi_prog_pkg::host_byte_t head,
   output logic                     pop,
   input  spi_prog_pkg::spi_rsp_t   rsp,
   output spi_prog_pkg::spi_cmd_t   cmd,
   output logic                     done
);

   localparam int WORD_W = (WORD_COUNT > 1) ? $clog2(WORD_COUNT) : 1;
   localparam int BYTE_W = $clog2(spi_prog_pkg::BYTES_PER_WORD);
   localparam int WAIT_W = (PROG_TIME > 0) ? $clog2(PROG_TIME + 1) : 1;

   localparam spi_prog_pkg::flash_addr_t FLASH_STEP =
      spi_prog_pkg::flash_addr_t'(spi_prog_pkg::BYTES_PER_WORD);  // Address step per word.

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_STATUS,
      ST_WREN,
      ST_PROG_WAIT,
      ST_PROGRAM,
      ST_DATA,
      ST_FINISHED
   } state_t;

   state_t                    state;
   spi_prog_pkg::flash_addr_t addr;
   logic [WORD_W-1:0]         word_cnt;
   logic [BYTE_W-1:0]         byte_cnt;
   logic [WAIT_W-1:0]         wait_cnt;
   logic                      waiting;    // Transfer launched, done not yet seen.
   logic                      launch_ok;
   logic                      last_byte;
   logic                      last_word;

   assign launch_ok = !waiting && rsp.idle;
   assign last_byte = (byte_cnt == BYTE_W'(spi_prog_pkg::BYTES_PER_WORD - 1));
   assign last_word = (word_cnt == WORD_W'(WORD_COUNT - 1));
   assign done      = (state == ST_FINISHED);

   always_comb
   begin
      cmd = '0;
      pop = 1'b0;
      case (state)
         ST_STATUS:
         begin
            cmd.tx_bits   = {spi_prog_pkg::OP_READ_STATUS, 24'h0};
            cmd.bit_count = 6'd8;
            cmd.rx_en     = 1'b1;
            cmd.launch    = launch_ok;
         end
         ST_WREN:
         begin
            cmd.tx_bits   = {spi_prog_pkg::OP_WRITE_ENABLE, 24'h0};
            cmd.bit_count = 6'd8;
            cmd.launch    = launch_ok;
         end
         ST_PROGRAM:
         begin
            cmd.tx_bits     = {spi_prog_pkg::OP_PAGE_PROGRAM, addr};
            cmd.bit_count   = 6'd32;
            cmd.hold_select = 1'b1;  // Data bytes follow in the same frame.
            cmd.launch      = launch_ok;
         end
         ST_DATA:
         begin
            cmd.tx_bits     = {head.data, 24'h0};
            cmd.bit_count   = 6'd8;
            cmd.hold_select = !last_byte;
            cmd.launch      = launch_ok && head.valid;  // Stall with select low.
            pop             = cmd.launch;
         end
         default:
         begin
            cmd = '0;
         end
      endcase
   end

   always_ff @(posedge HCLK or negedge HRESETN)
   begin
      if (!HRESETN)
      begin
         state    <= ST_IDLE;
         addr     <= START_ADDR;
         word_cnt <= '0;
         byte_cnt <= '0;
         wait_cnt <= '0;
         waiting  <= 1'b0;
      end
      else
      begin
         if (cmd.launch)
         begin
            waiting <= 1'b1;
         end
         case (state)
            ST_IDLE:
            begin
               if (start_program)
               begin
                  addr     <= START_ADDR;
                  word_cnt <= '0;
                  byte_cnt <= '0;
                  state    <= ST_STATUS;
               end
            end
            ST_STATUS:
            begin
               if (waiting && rsp.done)
               begin
                  waiting <= 1'b0;
                  if (!rsp.rx_byte[spi_prog_pkg::BUSY_BIT])
                  begin
                     state <= ST_WREN;
                  end
               end
            end
            ST_WREN:
            begin
               if (waiting && rsp.done)
               begin
                  waiting  <= 1'b0;
                  wait_cnt <= '0;
                  state    <= ST_PROG_WAIT;
               end
            end
            ST_PROG_WAIT:
            begin
               // Count starts once the write enable frame is deselected.
               if (!rsp.idle)
               begin
                  wait_cnt <= '0;
               end
               else if (wait_cnt == WAIT_W'(PROG_TIME))
               begin
                  state <= ST_PROGRAM;
               end
               else
               begin
                  wait_cnt <= wait_cnt + 1'b1;
               end
            end
            ST_PROGRAM:
            begin
               if (waiting && rsp.done)
               begin
                  waiting  <= 1'b0;
                  byte_cnt <= '0;
                  state    <= ST_DATA;
               end
            end
            ST_DATA:
            begin
               if (waiting && rsp.done)
               begin
                  waiting <= 1'b0;
                  if (last_byte)
                  begin
                     byte_cnt <= '0;
                     word_cnt <= word_cnt + 1'b1;
                     addr     <= addr + FLASH_STEP;
                     state    <= last_word ? ST_FINISHED : ST_STATUS;
                  end
                  else
                  begin
                     byte_cnt <= byte_cnt + 1'b1;
                  end
               end
            end
            ST_FINISHED:
            begin
               if (!start_program)
               begin
                  state <= ST_IDLE;
               end
            end
            default:
            begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

endmodule

/* source/spi_shift_engine.sv */
// SPI shift engine
module spi_shift_engine (
   input  logic                   HCLK,
   input  logic                   HRESETN,
   input  spi_prog_pkg::spi_cmd_t cmd,
   input  logic                   edge_lo,
   input  logic                   edge_hi,
   input  logic                   sdi,
   output logic                   clock_en,
   output logic                   sdo,
   output logic                   ss_n,
   output spi_prog_pkg::spi_rsp_t rsp
);

   logic [31:0]         shift_reg;
   spi_prog_pkg::byte_t rx_shift;
   logic [5:0]          bit_cnt;
   logic                busy;
   logic                rx_phase;         // Receiving the status byte.
   logic                rx_en_q;
   logic                hold_q;
   logic                release_pending;  // Deselect on the next edge_lo.
   logic                done;
   logic                idle;
   logic                start_xfer;
   logic                tx_step;
   logic                rx_step;

   assign idle       = !busy && !release_pending;
   assign start_xfer = cmd.launch && idle;
   assign tx_step    = busy && edge_lo && !rx_phase && (bit_cnt != '0);
   assign rx_step    = busy && edge_hi && rx_phase && (bit_cnt != '0);

   always_ff @(posedge HCLK)
   begin
      if (start_xfer)
      begin
         shift_reg <= cmd.tx_bits;
      end
      else if (tx_step)
      begin
         shift_reg <= {shift_reg[30:0], 1'b0};  // MSB first.
      end
      if (rx_step)
      begin
         rx_shift <= {rx_shift[6:0], sdi};
      end
   end

   always_ff @(posedge HCLK or negedge HRESETN)
   begin
      if (!HRESETN)
      begin
         busy            <= 1'b0;
         rx_phase        <= 1'b0;
         rx_en_q         <= 1'b0;
         hold_q          <= 1'b0;
         release_pending <= 1'b0;
         bit_cnt         <= '0;
         ss_n            <= 1'b1;
         sdo             <= 1'b0;
         clock_en        <= 1'b0;
         done            <= 1'b0;
      end
      else
      begin
         done <= 1'b0;
         if (start_xfer)
         begin
            busy     <= 1'b1;
            rx_phase <= 1'b0;
            bit_cnt  <= cmd.bit_count;
            rx_en_q  <= cmd.rx_en;
            hold_q   <= cmd.hold_select;
            ss_n     <= 1'b0;
         end
         else if (tx_step)
         begin
            clock_en <= 1'b1;
            sdo      <= shift_reg[31];
            bit_cnt  <= bit_cnt - 1'b1;
         end
         else if (busy && edge_lo && !rx_phase && rx_en_q)
         begin
            rx_phase <= 1'b1;  // Flash answers after the opcode.
            bit_cnt  <= 6'd8;
            sdo      <= 1'b0;
         end
         else if (busy && edge_lo && (!rx_phase || bit_cnt == '0))
         begin
            busy            <= 1'b0;
            rx_phase        <= 1'b0;
            clock_en        <= 1'b0;
            done            <= 1'b1;
            release_pending <= !hold_q;
         end
         else if (rx_step)
         begin
            bit_cnt <= bit_cnt - 1'b1;
         end
         else if (release_pending && edge_lo)
         begin
            ss_n            <= 1'b1;
            release_pending <= 1'b0;
         end
      end
   end

   assign rsp.done    = done;
   assign rsp.idle    = idle;
   assign rsp.rx_byte = rx_shift;

endmodule

/* source/spi_clock_timebase.sv */
// SPI clock timebase
module spi_clock_timebase #(
   parameter int SPI_CLK_RATIO = 4
) (
   input  logic HCLK,
   input  logic HRESETN,
   input  logic clock_en,
   output logic edge_lo,
   output logic edge_hi,
   output logic sck
);

   localparam int HALF  = SPI_CLK_RATIO / 2;
   localparam int CNT_W = (HALF > 1) ? $clog2(HALF) : 1;

   logic [CNT_W-1:0] half_cnt;
   logic             phase;      // High once edge_lo has fired.

   // Strobes run freely and alternate every half period.
   always_ff @(posedge HCLK or negedge HRESETN)
   begin
      if (!HRESETN)
      begin
         half_cnt <= '0;
         phase    <= 1'b0;
         edge_lo  <= 1'b0;
         edge_hi  <= 1'b0;
      end
      else if (half_cnt == CNT_W'(HALF - 1))
      begin
         half_cnt <= '0;
         phase    <= !phase;
         edge_lo  <= !phase;
         edge_hi  <= phase;
      end
      else
      begin
         half_cnt <= half_cnt + 1'b1;
         edge_lo  <= 1'b0;
         edge_hi  <= 1'b0;
      end
   end

   // Serial clock rests low whenever the engine is not shifting.
   always_ff @(posedge HCLK or negedge HRESETN)
   begin
      if (!HRESETN)
      begin
         sck <= 1'b0;
      end
      else if (clock_en)
      begin
         if (edge_hi)
         begin
            sck <= 1'b1;
         end
         else if (edge_lo)
         begin
            sck <= 1'b0;
         end
      end
   end

endmodule

/* source/host_byte_buffer.sv */
// Host byte FIFO with credit return
module host_byte_buffer #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                     HCLK,
   input  logic                     HRESETN,
   input  spi_prog_pkg::host_byte_t host_in,
   input  logic                     pop,
   output spi_prog_pkg::host_byte_t head,
   output logic                     credit_return
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   spi_prog_pkg::byte_t mem [FIFO_DEPTH];
   logic [PTR_W-1:0]    wr_ptr;
   logic [PTR_W-1:0]    rd_ptr;
   logic [CNT_W-1:0]    count;
   logic                do_pop;

   assign do_pop = pop && (count != '0);  // Ignore a pop on an empty FIFO.

   // Host credits guarantee a free slot for every valid byte.
   always_ff @(posedge HCLK)
   begin
      if (host_in.valid)
      begin
         mem[wr_ptr] <= host_in.data;
      end
   end

   always_ff @(posedge HCLK or negedge HRESETN)
   begin
      if (!HRESETN)
      begin
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         count         <= '0;
         credit_return <= 1'b0;
      end
      else
      begin
         if (host_in.valid)
         begin
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop)
         begin
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({host_in.valid, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         credit_return <= do_pop;  // One credit back per byte taken.
      end
   end

   assign head.valid = (count != '0);
   assign head.data  = mem[rd_ptr];

endmodule

/* source/spi_prog_pkg.sv */
// SPI flash programmer definitions
package spi_prog_pkg;

   localparam int FLASH_ADDR_W   = 24;
   localparam int BYTES_PER_WORD = 4;   // Data bytes after each program command.
   localparam int BUSY_BIT       = 0;   // Status bit set while a write is in progress.

   typedef logic [7:0] byte_t;
   typedef logic [FLASH_ADDR_W-1:0] flash_addr_t;

   localparam byte_t OP_READ_STATUS  = 8'h05;
   localparam byte_t OP_WRITE_ENABLE = 8'h06;
   localparam byte_t OP_PAGE_PROGRAM = 8'h02;

   // One byte from the host.
   typedef struct packed {
      logic  valid;
      byte_t data;
   } host_byte_t;

   // Transfer request from the sequencer to the shift engine.
   typedef struct packed {
      logic        launch;       // Single cycle start pulse.
      logic [31:0] tx_bits;      // Left aligned, sent MSB first.
      logic [5:0]  bit_count;    // 8 or 32.
      logic        rx_en;        // Read one byte after the transmit bits.
      logic        hold_select;  // Keep the flash selected afterwards.
   } spi_cmd_t;

   // Transfer status back to the sequencer.
   typedef struct packed {
      logic  done;
      logic  idle;
      byte_t rx_byte;
   } spi_rsp_t;

   // Flash side pins.
   typedef struct packed {
      logic sck;
      logic sdo;
      logic ss_n;
   } spi_pins_t;

endpackage
